// ==== hw/conbus_pkg.sv ====
// conbus shared definitions
// wishbone bus widths and the slave address map used by all interconnect blocks

`default_nettype none

package conbus_pkg;

	// bus widths
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	// one select bit per byte lane
	localparam int WB_SEL_W = WB_DAT_W / 8;

	// byte address on the bus
	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	// read or write data word
	typedef logic [WB_DAT_W-1:0] wb_dat_t;
	// byte-lane select
	typedef logic [WB_SEL_W-1:0] wb_sel_t;

	// upper address bits that pick the slave
	localparam int SLAVE_ADDR_W = 4;
	// lowest bit of the slave field
	localparam int SLAVE_ADDR_LSB = WB_ADR_W - SLAVE_ADDR_W;

	// first address bit above the byte offset
	localparam int WB_WORD_LSB = $clog2(WB_SEL_W);

endpackage

`default_nettype wire

// ==== hw/conbus_arb.sv ====
// conbus round-robin arbiter
// grants the shared bus to one master and holds the grant for the whole
// cycle, then rotates priority starting after the previous owner

`default_nettype none
`timescale 1ns/1ps

module conbus_arb #(
	parameter int NUM_MASTERS = 3
) (
	input  logic                   sys_clk_i,
	input  logic                   rst_i,
	input  logic [NUM_MASTERS-1:0] req_i,
	output logic [NUM_MASTERS-1:0] gnt_o
);

	// owner index width, at least one bit
	localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

	// current bus owner
	logic [IDX_W-1:0] owner_q;
	logic [IDX_W-1:0] owner_d;
	// registered one-hot grant
	logic [NUM_MASTERS-1:0] gnt_q;

	// next owner
	always_comb begin : next_owner
		int  cand;
		logic found;
		owner_d = owner_q;
		found = 1'b0;
		cand = 0;
		// owner keeps the bus while its cyc stays high
		if (!req_i[owner_q]) begin
			// rotating search, first requester after the owner wins
			for (int i = 1; i < NUM_MASTERS; i++) begin
				cand = int'(owner_q) + i;
				if (cand >= NUM_MASTERS)
					cand = cand - NUM_MASTERS;
				if (!found && req_i[cand]) begin
					owner_d = IDX_W'(cand);
					found = 1'b1;
				end
			end
		end
		// no requester found, grant stays parked
	end

	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			// master 0 owns the bus out of reset
			owner_q <= '0;
			gnt_q <= NUM_MASTERS'(1);
		end else begin
			owner_q <= owner_d;
			gnt_q <= NUM_MASTERS'(1) << owner_d;
		end
	end

	assign gnt_o = gnt_q;

	// exactly one master granted at all times
	a_gnt_onehot: assert property (
		@(posedge sys_clk_i) disable iff (rst_i)
		$onehot(gnt_o)
	);

	// no grant change while the owner still requests
	a_gnt_hold: assert property (
		@(posedge sys_clk_i) disable iff (rst_i)
		(|(gnt_o & req_i)) |=> $stable(gnt_o)
	);

endmodule

`default_nettype wire

// ==== hw/conbus.sv ====
// conbus wishbone shared-bus interconnect
// muxes the granted master onto one internal bus, decodes the upper
// address bits to a slave strobe and merges slave data and ack back

`default_nettype none
`timescale 1ns/1ps

module conbus import conbus_pkg::*; #(
	parameter int NUM_MASTERS = 3,
	parameter int NUM_SLAVES  = 4
) (
	input  logic                            sys_clk_i,
	input  logic                            rst_i,

	// master side, slot k per master
	input  logic [NUM_MASTERS*WB_ADR_W-1:0] m_adr_i,
	input  logic [NUM_MASTERS*WB_DAT_W-1:0] m_dat_i,
	input  logic [NUM_MASTERS*WB_SEL_W-1:0] m_sel_i,
	input  logic [NUM_MASTERS-1:0]          m_we_i,
	input  logic [NUM_MASTERS-1:0]          m_cyc_i,
	input  logic [NUM_MASTERS-1:0]          m_stb_i,
	output logic [NUM_MASTERS*WB_DAT_W-1:0] m_dat_o,
	output logic [NUM_MASTERS-1:0]          m_ack_o,

	// slave side, shared lines
	output wb_adr_t                         s_adr_o,
	output wb_dat_t                         s_dat_o,
	output wb_sel_t                         s_sel_o,
	output logic                            s_we_o,
	output logic                            s_cyc_o,
	// strobe only to the decoded slave
	output logic [NUM_SLAVES-1:0]           s_stb_o,
	input  logic [NUM_SLAVES*WB_DAT_W-1:0]  s_dat_i,
	input  logic [NUM_SLAVES-1:0]           s_ack_i
);

	// arbiter grant, one-hot
	logic [NUM_MASTERS-1:0] gnt;

	// internal shared bus, master to slave
	wb_adr_t bus_adr;
	wb_dat_t bus_dat;
	wb_sel_t bus_sel;
	logic    bus_we;
	logic    bus_cyc;
	logic    bus_stb;

	// internal shared bus, slave to master
	wb_dat_t bus_rdat;
	logic    bus_ack;

	// decoded slave, one-hot
	logic [NUM_SLAVES-1:0] slave_sel;

	// each master requests with its cyc
	conbus_arb #(
		.NUM_MASTERS(NUM_MASTERS)
	) conbus_arb0 (
		.sys_clk_i(sys_clk_i),
		.rst_i    (rst_i),
		.req_i    (m_cyc_i),
		.gnt_o    (gnt)
	);

	// and-or select of the granted master
	always_comb begin
		bus_adr = '0;
		bus_dat = '0;
		bus_sel = '0;
		bus_we  = 1'b0;
		bus_cyc = 1'b0;
		bus_stb = 1'b0;
		for (int k = 0; k < NUM_MASTERS; k++) begin
			bus_adr |= m_adr_i[k*WB_ADR_W +: WB_ADR_W] & {WB_ADR_W{gnt[k]}};
			bus_dat |= m_dat_i[k*WB_DAT_W +: WB_DAT_W] & {WB_DAT_W{gnt[k]}};
			bus_sel |= m_sel_i[k*WB_SEL_W +: WB_SEL_W] & {WB_SEL_W{gnt[k]}};
			bus_we  |= m_we_i[k] & gnt[k];
			bus_cyc |= m_cyc_i[k] & gnt[k];
			bus_stb |= m_stb_i[k] & gnt[k];
		end
	end

	// slave n sits at upper address field n
	always_comb begin
		for (int n = 0; n < NUM_SLAVES; n++)
			slave_sel[n] = (bus_adr[SLAVE_ADDR_LSB +: SLAVE_ADDR_W] == SLAVE_ADDR_W'(n));
	end

	// shared lines go to every slave
	assign s_adr_o = bus_adr;
	assign s_dat_o = bus_dat;
	assign s_sel_o = bus_sel;
	assign s_we_o  = bus_we;
	assign s_cyc_o = bus_cyc;
	// strobe gated by the decode
	assign s_stb_o = {NUM_SLAVES{bus_cyc & bus_stb}} & slave_sel;

	// idle slaves drive zero data, so plain or merge
	always_comb begin
		bus_rdat = '0;
		for (int n = 0; n < NUM_SLAVES; n++)
			bus_rdat |= s_dat_i[n*WB_DAT_W +: WB_DAT_W];
	end

	assign bus_ack = |s_ack_i;

	// data to all masters, ack only to the owner
	assign m_dat_o = {NUM_MASTERS{bus_rdat}};
	assign m_ack_o = {NUM_MASTERS{bus_ack}} & gnt;

	// decode must never let two slaves answer together
	a_ack_onehot0: assert property (
		@(posedge sys_clk_i) disable iff (rst_i)
		$onehot0(s_ack_i)
	);

endmodule

`default_nettype wire

// ==== hw/wb_sram.sv ====
// wishbone sram slave
// single-cycle classic access with byte-lane writes, registered read
// data and a one-cycle registered ack

`default_nettype none
`timescale 1ns/1ps

module wb_sram import conbus_pkg::*; #(
	parameter int SRAM_WORDS = 256
) (
	input  logic    sys_clk_i,
	input  logic    rst_i,
	input  wb_adr_t adr_i,
	input  wb_dat_t dat_i,
	input  wb_sel_t sel_i,
	input  logic    we_i,
	input  logic    cyc_i,
	input  logic    stb_i,
	output wb_dat_t dat_o,
	output logic    ack_o
);

	// word index width
	localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

	wb_dat_t mem [SRAM_WORDS];
	// word address, byte offset dropped
	logic [IDX_W-1:0] idx;
	// read word
	wb_dat_t rd_q;
	logic    ack_q;
	// new access, not the ack cycle of the previous one
	logic    access;

	assign idx = adr_i[WB_WORD_LSB +: IDX_W];
	assign access = cyc_i & stb_i & ~ack_q;

	// memory write by lane, read of the old word at the same edge
	always_ff @(posedge sys_clk_i) begin
		if (access) begin
			if (we_i) begin
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (sel_i[b])
						mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
				end
			end
			rd_q <= mem[idx];
		end
	end

	// ack pulse, one cycle after the strobe
	always_ff @(posedge sys_clk_i) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	assign ack_o = ack_q;
	// zero outside the ack cycle for the or merge in conbus
	assign dat_o = rd_q & {$bits(wb_dat_t){ack_q}};

	// ack only answers a strobe from the previous cycle
	a_ack_after_stb: assert property (
		@(posedge sys_clk_i) disable iff (rst_i)
		ack_o |-> $past(cyc_i & stb_i)
	);

endmodule

`default_nettype wire

// ==== hw/wb_subsys.sv ====
// wishbone subsystem top level
// three masters share conbus, which serves four identical sram slaves

`default_nettype none
`timescale 1ns/1ps

module wb_subsys import conbus_pkg::*; #(
	parameter int NUM_MASTERS = 3,
	parameter int NUM_SLAVES  = 4,
	parameter int SRAM_WORDS  = 256
) (
	input  logic                            sys_clk_i,
	input  logic                            rst_i,

	// master ports, slot k per master
	input  logic [NUM_MASTERS*WB_ADR_W-1:0] m_adr_i,
	input  logic [NUM_MASTERS*WB_DAT_W-1:0] m_dat_i,
	input  logic [NUM_MASTERS*WB_SEL_W-1:0] m_sel_i,
	input  logic [NUM_MASTERS-1:0]          m_we_i,
	input  logic [NUM_MASTERS-1:0]          m_cyc_i,
	input  logic [NUM_MASTERS-1:0]          m_stb_i,
	output logic [NUM_MASTERS*WB_DAT_W-1:0] m_dat_o,
	output logic [NUM_MASTERS-1:0]          m_ack_o
);

	// shared slave lines
	wb_adr_t s_adr;
	wb_dat_t s_wdat;
	wb_sel_t s_sel;
	logic    s_we;
	logic    s_cyc;
	// per-slave lines
	logic [NUM_SLAVES-1:0]          s_stb;
	logic [NUM_SLAVES-1:0]          s_ack;
	logic [NUM_SLAVES*WB_DAT_W-1:0] s_rdat;

	conbus #(
		.NUM_MASTERS(NUM_MASTERS),
		.NUM_SLAVES (NUM_SLAVES)
	) conbus0 (
		.sys_clk_i(sys_clk_i),
		.rst_i    (rst_i),
		.m_adr_i  (m_adr_i),
		.m_dat_i  (m_dat_i),
		.m_sel_i  (m_sel_i),
		.m_we_i   (m_we_i),
		.m_cyc_i  (m_cyc_i),
		.m_stb_i  (m_stb_i),
		.m_dat_o  (m_dat_o),
		.m_ack_o  (m_ack_o),
		.s_adr_o  (s_adr),
		.s_dat_o  (s_wdat),
		.s_sel_o  (s_sel),
		.s_we_o   (s_we),
		.s_cyc_o  (s_cyc),
		.s_stb_o  (s_stb),
		.s_dat_i  (s_rdat),
		.s_ack_i  (s_ack)
	);

	// one sram per address field value
	for (genvar n = 0; n < NUM_SLAVES; n++) begin : g_sram
		wb_sram #(
			.SRAM_WORDS(SRAM_WORDS)
		) sram (
			.sys_clk_i(sys_clk_i),
			.rst_i    (rst_i),
			.adr_i    (s_adr),
			.dat_i    (s_wdat),
			.sel_i    (s_sel),
			.we_i     (s_we),
			.cyc_i    (s_cyc),
			.stb_i    (s_stb[n]),
			.dat_o    (s_rdat[n*WB_DAT_W +: WB_DAT_W]),
			.ack_o    (s_ack[n])
		);
	end

endmodule

`default_nettype wire

// ==== test/tb_wb_subsys.sv ====
// testbench for the wishbone subsystem
// table of single cycles on three masters checked against a reference memory,
// then all three masters contending for the bus

`default_nettype none
`timescale 1ns/1ps

module tb_wb_subsys import conbus_pkg::*;;

	localparam int NM = 3;
	localparam int NS = 4;
	localparam int WORDS = 256;
	localparam int WIDX_W = $clog2(WORDS);
	// watchdog allowance per bus cycle, in clocks
	localparam int CYC_BUDGET = 20;
	localparam int CLK_NS = 20;

	// one table row
	typedef struct packed {
		logic [1:0] mst;
		logic       we;
		wb_adr_t    adr;
		wb_sel_t    sel;
		wb_dat_t    tag;
	} op_t;

	logic sys_clk;
	logic rst;
	// per-master drive, packed onto the dut ports
	wb_adr_t       adr [NM];
	wb_dat_t       wdat [NM];
	wb_sel_t       sel [NM];
	logic [NM-1:0] we;
	logic [NM-1:0] cyc;
	logic [NM-1:0] stb;
	logic [NM*WB_ADR_W-1:0] m_adr;
	logic [NM*WB_DAT_W-1:0] m_wdat;
	logic [NM*WB_SEL_W-1:0] m_sel;
	logic [NM*WB_DAT_W-1:0] m_rdat;
	logic [NM-1:0]          m_ack;

	op_t     ops [$];
	// reference memory, slave by word
	wb_dat_t ref_mem [NS][WORDS];
	integer  seed = 32'h14a0_aefa;
	int      errors = 0;
	int      checks = 0;
	bit      table_built = 1'b0;
	bit      count_acks = 1'b0;
	int      ack_cnt [NM];

	always_comb begin
		for (int k = 0; k < NM; k++) begin
			m_adr[k*WB_ADR_W +: WB_ADR_W] = adr[k];
			m_wdat[k*WB_DAT_W +: WB_DAT_W] = wdat[k];
			m_sel[k*WB_SEL_W +: WB_SEL_W] = sel[k];
		end
	end

	wb_subsys #(
		.NUM_MASTERS(NM),
		.NUM_SLAVES (NS),
		.SRAM_WORDS (WORDS)
	) dut0 (
		.sys_clk_i(sys_clk),
		.rst_i    (rst),
		.m_adr_i  (m_adr),
		.m_dat_i  (m_wdat),
		.m_sel_i  (m_sel),
		.m_we_i   (we),
		.m_cyc_i  (cyc),
		.m_stb_i  (stb),
		.m_dat_o  (m_rdat),
		.m_ack_o  (m_ack)
	);

	initial sys_clk = 1'b0;
	always #10 sys_clk = ~sys_clk;

	// slave number in the top bits, word index above the byte offset
	function automatic wb_adr_t make_adr(int s, int w);
		return (wb_adr_t'(s) << SLAVE_ADDR_LSB) | (wb_adr_t'(w) << WB_WORD_LSB);
	endfunction

	function automatic void add_op(int m, bit w_en, int s, int w, wb_sel_t be, wb_dat_t tag);
		op_t op;
		op.mst = 2'(m);
		op.we = w_en;
		op.adr = make_adr(s, w);
		op.sel = be;
		op.tag = tag;
		ops.push_back(op);
	endfunction

	// only the selected byte lanes change
	function automatic void model_write(wb_adr_t a, wb_sel_t be, wb_dat_t d);
		int s;
		int w;
		s = int'(a[SLAVE_ADDR_LSB +: SLAVE_ADDR_W]);
		w = int'(a[WB_WORD_LSB +: WIDX_W]);
		for (int b = 0; b < WB_SEL_W; b++)
			if (be[b])
				ref_mem[s][w][b*8 +: 8] = d[b*8 +: 8];
	endfunction

	function automatic void build_table();
		// full word to every slave through every master, read back at once
		for (int m = 0; m < NM; m++)
			for (int s = 0; s < NS; s++) begin
				add_op(m, 1'b1, s, 16 * m + s, 4'hf, 32'h0);
				add_op(m, 1'b0, s, 16 * m + s, 4'hf, 32'h0);
			end
		// byte merges on one word
		add_op(0, 1'b1, 1, 32, 4'hf, 32'h1111_0000);
		add_op(1, 1'b1, 1, 32, 4'h1, 32'h0000_00a5);
		add_op(2, 1'b1, 1, 32, 4'ha, 32'h5a00_5a00);
		add_op(0, 1'b1, 1, 32, 4'h6, 32'h00c3_c300);
		add_op(1, 1'b0, 1, 32, 4'hf, 32'h0);
		add_op(2, 1'b1, 3, 33, 4'hf, 32'h2222_0000);
		add_op(0, 1'b1, 3, 33, 4'h8, 32'h7e00_0000);
		add_op(2, 1'b0, 3, 33, 4'hf, 32'h0);
		// same offset in all four slaves
		for (int s = 0; s < NS; s++)
			add_op(s % NM, 1'b1, s, 64, 4'hf, 32'h4000_0000 + 32'(s));
		for (int s = 0; s < NS; s++)
			add_op((s + 1) % NM, 1'b0, s, 64, 4'hf, 32'h0);
	endfunction

	// one classic cycle, held until ack
	task automatic bus_cycle(input int k, input logic w_en, input wb_adr_t a,
			input wb_sel_t be, input wb_dat_t d, output wb_dat_t rd);
		@(negedge sys_clk);
		adr[k] = a;
		wdat[k] = d;
		sel[k] = be;
		we[k] = w_en;
		cyc[k] = 1'b1;
		stb[k] = 1'b1;
		@(negedge sys_clk);
		while (!m_ack[k])
			@(negedge sys_clk);
		rd = m_rdat[k*WB_DAT_W +: WB_DAT_W];
		cyc[k] = 1'b0;
		stb[k] = 1'b0;
		we[k] = 1'b0;
	endtask

	task automatic check_read(input wb_adr_t a, input wb_dat_t rd);
		wb_dat_t exp;
		exp = ref_mem[a[SLAVE_ADDR_LSB +: SLAVE_ADDR_W]][a[WB_WORD_LSB +: WIDX_W]];
		checks++;
		assert (rd === exp) else begin
			errors++;
			$display("[FAIL] %0t: read at %h gave %h, expected %h", $time, a, rd, exp);
		end
	endtask

	// ack monitor, sampled mid-cycle
	always @(negedge sys_clk) begin
		if (!rst) begin
			assert ($countones(m_ack) <= 1) else begin
				errors++;
				$display("[FAIL] %0t: two masters acked together, m_ack_o=%b", $time, m_ack);
			end
			if (count_acks)
				for (int k = 0; k < NM; k++)
					if (m_ack[k])
						ack_cnt[k]++;
		end
	end

	initial begin : watchdog
		wait (table_built);
		#((ops.size() + 2 * NM + 2) * CYC_BUDGET * CLK_NS);
		$display("timeout: the bus cycles did not finish in time, run stopped");
		$display("Test failed");
		$finish;
	end

	initial begin : main
		wb_dat_t d;
		wb_dat_t rd;
		wb_adr_t c_adr [NM];
		wb_dat_t c_dat [NM];
		wb_dat_t c_rd [NM];
		rst = 1'b1;
		cyc = '0;
		stb = '0;
		we = '0;
		for (int k = 0; k < NM; k++) begin
			adr[k] = '0;
			wdat[k] = '0;
			sel[k] = '0;
			ack_cnt[k] = 0;
		end
		build_table();
		table_built = 1'b1;
		// no ack during reset or on an idle bus
		for (int i = 0; i < 6; i++) begin
			@(negedge sys_clk);
			checks++;
			assert (m_ack == '0) else begin
				errors++;
				$display("[FAIL] %0t: m_ack_o=%b with no cycle", $time, m_ack);
			end
			if (i == 2)
				rst = 1'b0;
		end
		foreach (ops[i]) begin
			d = '0;
			if (ops[i].we)
				d = $random(seed) ^ ops[i].tag;
			bus_cycle(int'(ops[i].mst), ops[i].we, ops[i].adr, ops[i].sel, d, rd);
			if (ops[i].we)
				model_write(ops[i].adr, ops[i].sel, d);
			else
				check_read(ops[i].adr, rd);
		end
		// contention, all masters start on the same edge
		for (int k = 0; k < NM; k++) begin
			c_adr[k] = make_adr(k + 1, 128 + k);
			c_dat[k] = $random(seed);
		end
		@(posedge sys_clk);
		count_acks = 1'b1;
		fork
			bus_cycle(0, 1'b1, c_adr[0], 4'hf, c_dat[0], c_rd[0]);
			bus_cycle(1, 1'b1, c_adr[1], 4'hf, c_dat[1], c_rd[1]);
			bus_cycle(2, 1'b1, c_adr[2], 4'hf, c_dat[2], c_rd[2]);
		join
		@(posedge sys_clk);
		count_acks = 1'b0;
		for (int k = 0; k < NM; k++) begin
			checks++;
			assert (ack_cnt[k] == 1) else begin
				errors++;
				$display("[FAIL] %0t: master %0d got %0d acks", $time, k, ack_cnt[k]);
			end
			model_write(c_adr[k], 4'hf, c_dat[k]);
		end
		// read back through another master
		for (int k = 0; k < NM; k++) begin
			bus_cycle((k + 1) % NM, 1'b0, c_adr[k], 4'hf, '0, rd);
			check_read(c_adr[k], rd);
		end
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/conbus_pkg.sv
hw/conbus_arb.sv
hw/conbus.sv
hw/wb_sram.sv
hw/wb_subsys.sv
test/tb_wb_subsys.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv test/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_wb_subsys

obj_dir/Vtb_wb_subsys: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_wb_subsys \
		-f tb.f -o Vtb_wb_subsys

run: obj_dir/Vtb_wb_subsys
	@out="$$(./obj_dir/Vtb_wb_subsys)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf obj_dir
